// ==== rtl/esp_link_pkg.sv ====
package esp_link_pkg;

    // Bus and register geometry
    parameter int BYTE_W            = 8;   // ESP32 parallel bus width
    parameter int WORD_W            = 32;  // Register word width
    parameter int BYTES_PER_WORD    = 4;   // Bytes packed per word
    parameter int ADDR_W            = 5;   // Register address width
    parameter int NUM_REGS          = 32;  // Registers in the bank

    // Address sequence wraps from here back to 1
    parameter int DEFAULT_LAST_ADDR = 31;

    // One byte off the ESP32 bus
    typedef logic [BYTE_W-1:0] esp_byte_t;

    // One register word, MSB byte first
    typedef logic [WORD_W-1:0] reg_word_t;

    // Register index
    typedef logic [ADDR_W-1:0] reg_addr_t;

    // Completed passes over registers 1..LAST_ADDR
    typedef logic [15:0] frame_cnt_t;

endpackage

// ==== rtl/esp_word_assembler.sv ====
`timescale 1ns/100ps

module esp_word_assembler #(
    parameter esp_link_pkg::reg_addr_t LAST_ADDR =
        esp_link_pkg::reg_addr_t'(esp_link_pkg::DEFAULT_LAST_ADDR)
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  esp_link_pkg::esp_byte_t   esp_in,       // Sampled on every rising edge
    output logic                      addr_strobe,  // First byte of a word taken
    output esp_link_pkg::reg_addr_t   word_addr,    // Address for that word
    output logic                      word_strobe,  // Fourth byte taken, word complete
    output esp_link_pkg::reg_word_t   word_data     // Completed word
);
    import esp_link_pkg::*;

    localparam int CNT_W = $clog2(BYTES_PER_WORD);

    reg_word_t        shift_reg;    // Bytes shift in from the low end
    logic [CNT_W-1:0] byte_cnt;     // Position of the next byte in its word
    reg_addr_t        next_addr;    // Address handed to the next word
    logic             first_byte;   // Byte at this edge opens a word
    logic             last_byte;    // Byte at this edge closes a word
    reg_addr_t        addr_after;   // Sequence step after next_addr

    assign first_byte = (byte_cnt == '0);
    assign last_byte  = (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));

    // Register 0 only once, then 1..LAST_ADDR round and round
    always_comb begin
        if (next_addr == LAST_ADDR) begin
            addr_after = reg_addr_t'(1);  // Wrap skips the control word
        end else begin
            addr_after = next_addr + reg_addr_t'(1);
        end
    end

    // Shift register, one byte per clock, MSB first
    always_ff @(posedge clk) begin
        if (!nrst) begin
            shift_reg <= '0;  // Partial word is dropped
        end else begin
            shift_reg <= {shift_reg[WORD_W-BYTE_W-1:0], esp_in};
        end
    end

    // Byte position inside the current word
    always_ff @(posedge clk) begin
        if (!nrst) begin
            byte_cnt <= '0;
        end else if (last_byte) begin
            byte_cnt <= '0;  // Next byte starts a new word
        end else begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // Address bookkeeping
    always_ff @(posedge clk) begin
        if (!nrst) begin
            next_addr <= '0;  // Control word comes first
            word_addr <= '0;
        end else if (first_byte) begin
            word_addr <= next_addr;   // Latched with the first byte
            next_addr <= addr_after;
        end
    end

    // Strobes, one cycle after the byte that triggers them
    always_ff @(posedge clk) begin
        if (!nrst) begin
            addr_strobe <= 1'b0;
            word_strobe <= 1'b0;
        end else begin
            addr_strobe <= first_byte;
            word_strobe <= last_byte;
        end
    end

    // Shift register holds the full word during the word_strobe cycle
    assign word_data = shift_reg;

endmodule

// ==== rtl/ext_reg_writer.sv ====
`timescale 1ns/100ps

module ext_reg_writer #(
    parameter esp_link_pkg::reg_addr_t LAST_ADDR =
        esp_link_pkg::reg_addr_t'(esp_link_pkg::DEFAULT_LAST_ADDR)
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      addr_strobe,
    input  esp_link_pkg::reg_addr_t   word_addr,
    input  logic                      word_strobe,
    input  esp_link_pkg::reg_word_t   word_data,
    output logic                      wr_en,        // One-cycle write pulse
    output esp_link_pkg::reg_addr_t   wr_addr,
    output esp_link_pkg::reg_word_t   wr_data,
    output logic                      frame_done,   // Same cycle as write to LAST_ADDR
    output esp_link_pkg::frame_cnt_t  frame_count
);
    import esp_link_pkg::*;

    reg_addr_t pend_addr;    // Address waiting for its word
    logic      pend_valid;   // pend_addr belongs to an open word
    logic      commit;       // Word arrives with an address in hand
    logic      last_slot;    // Committed address closes a frame

    assign commit    = word_strobe && pend_valid;
    assign last_slot = (pend_addr == LAST_ADDR);

    // Pending address, held three cycles until the word shows up
    always_ff @(posedge clk) begin
        if (!nrst) begin
            pend_valid <= 1'b0;
        end else if (addr_strobe) begin
            pend_valid <= 1'b1;  // New word opened
        end else if (word_strobe) begin
            pend_valid <= 1'b0;  // Consumed, or orphan word dropped
        end
    end

    always_ff @(posedge clk) begin
        if (addr_strobe) begin
            pend_addr <= word_addr;
        end
    end

    // Write pulse and frame marker
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            wr_en      <= commit;
            frame_done <= commit && last_slot;
        end
    end

    // Write payload, only meaningful under wr_en
    always_ff @(posedge clk) begin
        if (commit) begin
            wr_addr <= pend_addr;
            wr_data <= word_data;
        end
    end

    // Frame counter steps on the edge that stores the LAST_ADDR word
    always_ff @(posedge clk) begin
        if (!nrst) begin
            frame_count <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + frame_cnt_t'(1);  // Rolls over silently
        end
    end

endmodule

// ==== rtl/ext_reg_bank.sv ====
`timescale 1ns/100ps

module ext_reg_bank (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      wr_en,
    input  esp_link_pkg::reg_addr_t   wr_addr,
    input  esp_link_pkg::reg_word_t   wr_data,
    input  esp_link_pkg::reg_addr_t   rd_addr,
    output esp_link_pkg::reg_word_t   rd_data
);
    import esp_link_pkg::*;

    reg_word_t regs [NUM_REGS];  // Register file, entry 0 is control

    // Synchronous write, whole bank cleared in reset
    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Plain read, a write shows up only after its edge
    assign rd_data = regs[rd_addr];

endmodule

// ==== rtl/esp_ext_reg_top.sv ====
`timescale 1ns/100ps

module esp_ext_reg_top #(
    parameter esp_link_pkg::reg_addr_t LAST_ADDR =
        esp_link_pkg::reg_addr_t'(esp_link_pkg::DEFAULT_LAST_ADDR)
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  esp_link_pkg::esp_byte_t   esp_in,       // Byte stream from the ESP32
    input  esp_link_pkg::reg_addr_t   rd_addr,
    output esp_link_pkg::reg_word_t   rd_data,
    output logic                      frame_done,
    output esp_link_pkg::frame_cnt_t  frame_count,
    output logic                      sclk_out      // Sampling clock back to the ESP32
);
    import esp_link_pkg::*;

    // Assembler to writer
    logic      addr_strobe;
    reg_addr_t word_addr;
    logic      word_strobe;
    reg_word_t word_data;

    // Writer to bank
    logic      wr_en;
    reg_addr_t wr_addr;
    reg_word_t wr_data;

    assign sclk_out = clk;  // Forwarded as is

    // Stage 1, bytes to words
    esp_word_assembler #(
        .LAST_ADDR   (LAST_ADDR)
    ) u_assembler (
        .clk         (clk),
        .nrst        (nrst),
        .esp_in      (esp_in),
        .addr_strobe (addr_strobe),
        .word_addr   (word_addr),
        .word_strobe (word_strobe),
        .word_data   (word_data)
    );

    // Stage 2, address pairing and frame tracking
    ext_reg_writer #(
        .LAST_ADDR   (LAST_ADDR)
    ) u_writer (
        .clk         (clk),
        .nrst        (nrst),
        .addr_strobe (addr_strobe),
        .word_addr   (word_addr),
        .word_strobe (word_strobe),
        .word_data   (word_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .frame_done  (frame_done),
        .frame_count (frame_count)
    );

    // Stage 3, register file
    ext_reg_bank u_bank (
        .clk         (clk),
        .nrst        (nrst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

// ==== include/esp_tb_checks.svh ====
`ifndef ESP_TB_CHECKS_SVH
`define ESP_TB_CHECKS_SVH

// Report a failure and stop the run
task automatic tb_fail(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
endtask

// Compare one register word
task automatic check_word(
    input string                   test_name,
    input esp_link_pkg::reg_word_t expected,
    input esp_link_pkg::reg_word_t actual
);
    string msg;
    if (actual !== expected) begin
        msg = $sformatf("FAILED %s: expected %h, actual %h", test_name, expected, actual);
        tb_fail(msg);
    end
endtask

// Compare the frame counter
task automatic check_frames(
    input string                    test_name,
    input esp_link_pkg::frame_cnt_t expected,
    input esp_link_pkg::frame_cnt_t actual
);
    string msg;
    if (actual !== expected) begin
        msg = $sformatf("FAILED %s: expected %0d frames, actual %0d",
                        test_name, expected, actual);
        tb_fail(msg);
    end
endtask

// Compare a single-bit output level
task automatic check_level(
    input string test_name,
    input logic  expected,
    input logic  actual
);
    string msg;
    if (actual !== expected) begin
        msg = $sformatf("FAILED %s: expected %b, actual %b", test_name, expected, actual);
        tb_fail(msg);
    end
endtask

`endif

// ==== test/esp_ext_reg_tb.sv ====
`timescale 1ns/100ps

module esp_ext_reg_tb;
    import esp_link_pkg::*;

    `include "esp_tb_checks.svh"

    localparam reg_addr_t LAST_ADDR   = reg_addr_t'(7);  // Short frames so wraps come quickly
    localparam int        RAND_SEED   = 70264;
    localparam int        WRAP_FRAMES = 5;               // Frames driven in wrap_overwrite
    localparam esp_byte_t IDLE_BYTE   = '0;              // Bus value between bursts
    localparam int        SETTLE_CYC  = 4;               // Idle cycles before a sweep

    // Last byte of a word sampled at edge E is readable after edge E+2
    localparam int        LAG_BYTES   = 2;

    // Longest run is under 400 cycles so the limit leaves a wide margin
    localparam int        TIMEOUT_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       nrst;
    esp_byte_t  esp_in;
    reg_addr_t  rd_addr;
    reg_word_t  rd_data;
    logic       frame_done;
    frame_cnt_t frame_count;
    logic       sclk_out;

    esp_byte_t  sent [$];          // Bytes sampled by the DUT since the last reset
    frame_cnt_t pulse_count;       // frame_done pulses seen since the last reset
    logic       sweep_active;      // Comparison process enabled
    string      test_name;         // Behavior under test
    int         cycle_cnt = 0;

    esp_ext_reg_top #(
        .LAST_ADDR   (LAST_ADDR)
    ) DUT (
        .clk         (clk),
        .nrst        (nrst),
        .esp_in      (esp_in),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_done  (frame_done),
        .frame_count (frame_count),
        .sclk_out    (sclk_out)
    );

    always #4 clk = ~clk;  // 8 ns period

    // Expected bank contents and frame count from the bytes seen so far
    function automatic void ref_model(
        input  esp_byte_t  bytes [$],
        input  int         n_bytes,
        output reg_word_t  regs [NUM_REGS],
        output frame_cnt_t frames
    );
        int        n_words;
        int        base;
        reg_addr_t addr;
        reg_word_t word;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        frames  = '0;
        n_words = n_bytes / BYTES_PER_WORD;  // Trailing partial word ignored
        for (int k = 0; k < n_words; k++) begin
            base = k * BYTES_PER_WORD;
            word = '0;
            for (int j = 0; j < BYTES_PER_WORD; j++) begin
                word[WORD_W-1-j*BYTE_W -: BYTE_W] = bytes[base+j];  // MSB first
            end
            if (k == 0) begin
                addr = '0;  // Control word
            end else begin
                addr = reg_addr_t'(((k - 1) % int'(LAST_ADDR)) + 1);
            end
            regs[addr] = word;
            if (k > 0 && addr == LAST_ADDR) begin
                frames = frames + frame_cnt_t'(1);
            end
        end
    endfunction

    // Record what the DUT samples and clear it with the DUT reset
    always @(posedge clk) begin
        if (!nrst) begin
            sent.delete();
        end else begin
            sent.push_back(esp_in);
        end
    end

    // Count frame_done pulses
    always @(posedge clk) begin
        if (!nrst) begin
            pulse_count <= '0;
        end else if (frame_done) begin
            pulse_count <= pulse_count + frame_cnt_t'(1);
        end
    end

    // Comparison on the falling edge, where rd_data has settled
    always @(negedge clk) begin
        reg_word_t  exp_regs [NUM_REGS];
        frame_cnt_t exp_frames;
        int         visible;
        if (sweep_active) begin
            visible = (sent.size() > LAG_BYTES) ? sent.size() - LAG_BYTES : 0;
            ref_model(sent, visible, exp_regs, exp_frames);
            check_word($sformatf("%s reg %0d", test_name, rd_addr), exp_regs[rd_addr], rd_data);
            check_frames({test_name, " frame_count"}, exp_frames, frame_count);
            check_frames({test_name, " frame_done pulses"}, exp_frames, pulse_count);
        end
    end

    // Forwarded clock follows clk in both phases
    always @(clk) begin
        #1;
        check_level("clock_forward sclk_out", clk, sclk_out);
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            tb_fail($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // Reset held low for two rising edges with the bus idle
    task automatic apply_reset();
        @(posedge clk);
        nrst   <= 1'b0;
        esp_in <= IDLE_BYTE;
        repeat (2) @(posedge clk);
        nrst   <= 1'b1;
    endtask

    task automatic drive_random_byte();
        @(posedge clk);
        esp_in <= esp_byte_t'($urandom);
    endtask

    task automatic send_words(input int n_words);
        repeat (n_words * BYTES_PER_WORD) begin
            drive_random_byte();
        end
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        esp_in <= IDLE_BYTE;
        repeat (n - 1) @(posedge clk);
    endtask

    // Read every register once while idle bytes keep flowing
    task automatic sweep_regs(input string name);
        test_name = name;
        for (int a = 0; a < NUM_REGS; a++) begin
            @(posedge clk);
            esp_in       <= IDLE_BYTE;
            rd_addr      <= reg_addr_t'(a);
            sweep_active <= 1'b1;
        end
        @(posedge clk);
        sweep_active <= 1'b0;
    endtask

    // Stop so that the byte already on the bus is the second of a word
    task automatic align_partial_word();
        @(negedge clk);
        while (sent.size() % BYTES_PER_WORD != 1) begin
            drive_random_byte();
            @(negedge clk);
        end
    endtask

    initial begin
        nrst         = 1'b0;
        esp_in       = IDLE_BYTE;
        rd_addr      = '0;
        sweep_active = 1'b0;
        pulse_count  = '0;
        void'($urandom(RAND_SEED));

        apply_reset();
        sweep_regs("reset_clear");

        apply_reset();
        send_words(1);
        idle_cycles(SETTLE_CYC);
        sweep_regs("first_word");

        apply_reset();
        send_words(1 + int'(LAST_ADDR));  // Control word plus one frame
        idle_cycles(SETTLE_CYC);
        sweep_regs("fill_order");

        send_words(WRAP_FRAMES * int'(LAST_ADDR));  // No reset so the addresses keep wrapping
        idle_cycles(SETTLE_CYC);
        sweep_regs("wrap_overwrite");

        align_partial_word();
        apply_reset();    // Two bytes of a word are in the DUT here
        send_words(1);
        idle_cycles(SETTLE_CYC);
        sweep_regs("midword_reset");

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
rtl/esp_link_pkg.sv
rtl/esp_word_assembler.sv
rtl/ext_reg_writer.sv
rtl/ext_reg_bank.sv
rtl/esp_ext_reg_top.sv
test/esp_ext_reg_tb.sv

// ==== Makefile ====
# Verilator build and run for the ESP32 byte link testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= esp_ext_reg_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell grep -v '^+' $(FLIST)) include/esp_tb_checks.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Run the simulation; the status is set by a search for the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
